// ==== common/fetch_pkg.sv ====
package fetch_pkg;

    // btb geometry, index is pc[7:2] and tag is pc[31:8]
    localparam int btb_entries = 64;
    localparam int btb_index_bits = 6;

    // return stack geometry
    localparam int ras_depth = 8;
    localparam int ras_ptr_bits = 3;

    localparam logic [31:0] reset_vector = 32'hbfc0_0000;

    // opcode and funct values seen by the predecoder
    localparam logic [5:0] op_special = 6'h00;
    localparam logic [5:0] op_jal = 6'h03;
    localparam logic [5:0] funct_jr = 6'h08;
    localparam logic [5:0] funct_jalr = 6'h09;
    localparam logic [4:0] reg_ra = 5'd31;

    // where next_pc came from
    localparam logic [1:0] src_seq = 2'd0;
    localparam logic [1:0] src_btb = 2'd1;
    localparam logic [1:0] src_ras = 2'd2;
    localparam logic [1:0] src_redirect = 2'd3;

    typedef struct packed {
        logic [5:0] opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } r_view_t;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [25:0] index;
    } j_view_t;

    // one fetched word, read as r-type or j-type
    typedef union packed {
        r_view_t r;
        j_view_t j;
    } instr_u;

endpackage

// ==== common/pred_if.sv ====
interface pred_if;

    // btb lookup result
    logic        btb_hit;
    logic        btb_taken;
    logic [31:0] btb_target;

    // return stack lookup result
    logic        ras_hit;
    logic [31:0] ras_target;

    modport btb (
        output btb_hit,
        output btb_taken,
        output btb_target
    );

    modport ras (
        output ras_hit,
        output ras_target
    );

    modport sel (
        input btb_hit,
        input btb_taken,
        input btb_target,
        input ras_hit,
        input ras_target
    );

endinterface

// ==== common/update_if.sv ====
interface update_if;

    // one strobe per committed branch
    logic        valid;
    logic [31:0] pc;
    logic        taken;
    logic [31:0] target;

    modport src (
        output valid,
        output pc,
        output taken,
        output target
    );

    modport btb (
        input valid,
        input pc,
        input taken,
        input target
    );

endinterface

// ==== branch_predict/btb_predictor.sv ====
module btb_predictor (
    input logic        clk,
    input logic        rst_n,
    input logic [31:0] pc,
    update_if.btb      upd,
    pred_if.btb        pred
);

    // only the valid bits are control state
    logic [fetch_pkg::btb_entries-1:0] valid_q;
    logic [31:fetch_pkg::btb_index_bits+2] tag_q [fetch_pkg::btb_entries];
    logic [31:0] target_q [fetch_pkg::btb_entries];
    logic [1:0]  ctr_q [fetch_pkg::btb_entries];

    logic [fetch_pkg::btb_index_bits-1:0] rd_idx;
    logic [fetch_pkg::btb_index_bits-1:0] wr_idx;
    logic [31:fetch_pkg::btb_index_bits+2] rd_tag;
    logic [31:fetch_pkg::btb_index_bits+2] wr_tag;
    logic        upd_hit;
    logic [1:0]  cnt_cur;
    logic [1:0]  cnt_next;

    // lookup side
    assign rd_idx = pc[fetch_pkg::btb_index_bits+1:2];
    assign rd_tag = pc[31:fetch_pkg::btb_index_bits+2];

    assign pred.btb_hit = valid_q[rd_idx] && (tag_q[rd_idx] == rd_tag);
    assign pred.btb_taken = pred.btb_hit && ctr_q[rd_idx][1];
    assign pred.btb_target = target_q[rd_idx];

    // update side
    assign wr_idx = upd.pc[fetch_pkg::btb_index_bits+1:2];
    assign wr_tag = upd.pc[31:fetch_pkg::btb_index_bits+2];
    assign upd_hit = valid_q[wr_idx] && (tag_q[wr_idx] == wr_tag);
    assign cnt_cur = ctr_q[wr_idx];

    // 2-bit saturating counter
    always_comb begin
        cnt_next = cnt_cur;
        if (upd.taken && cnt_cur != 2'd3) begin
            cnt_next = cnt_cur + 2'd1;
        end else if (!upd.taken && cnt_cur != 2'd0) begin
            cnt_next = cnt_cur - 2'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else if (upd.valid && upd.taken && !upd_hit) begin
            valid_q[wr_idx] <= 1'b1;
        end
    end

    // a not-taken miss leaves the entry alone
    always_ff @(posedge clk) begin
        if (upd.valid && (upd_hit || upd.taken)) begin
            tag_q[wr_idx] <= wr_tag;
            // new entries start weakly taken
            ctr_q[wr_idx] <= upd_hit ? cnt_next : 2'b10;
            if (upd.taken) begin
                target_q[wr_idx] <= upd.target;
            end
        end
    end

endmodule

// ==== branch_predict/return_stack.sv ====
module return_stack (
    input logic              clk,
    input logic              rst_n,
    input logic [31:0]       pc,
    input fetch_pkg::instr_u instr,
    input logic              advance,
    input logic              flush,
    pred_if.ras              pred
);

    logic [31:0] stack_q [fetch_pkg::ras_depth];
    // top_q points at the newest entry
    logic [fetch_pkg::ras_ptr_bits-1:0] top_q;
    logic [fetch_pkg::ras_ptr_bits:0]   count_q;
    logic [fetch_pkg::ras_ptr_bits-1:0] push_ptr;
    logic is_call;
    logic is_ret;
    logic empty;

    // jal, or jalr linking to ra
    assign is_call = (instr.j.opcode == fetch_pkg::op_jal)
        || (instr.r.opcode == fetch_pkg::op_special
            && instr.r.funct == fetch_pkg::funct_jalr
            && instr.r.rd == fetch_pkg::reg_ra);

    // jr $ra
    assign is_ret = instr.r.opcode == fetch_pkg::op_special
        && instr.r.funct == fetch_pkg::funct_jr
        && instr.r.rs == fetch_pkg::reg_ra;

    assign empty = (count_q == '0);
    assign push_ptr = top_q + 1'b1;

    assign pred.ras_hit = is_ret && !empty;
    assign pred.ras_target = stack_q[top_q];

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            top_q <= '0;
            count_q <= '0;
        end else if (advance) begin
            if (is_call) begin
                // full stack wraps over the oldest entry
                top_q <= push_ptr;
                if (count_q != fetch_pkg::ras_depth) begin
                    count_q <= count_q + 1'b1;
                end
            end else if (is_ret && !empty) begin
                top_q <= top_q - 1'b1;
                count_q <= count_q - 1'b1;
            end
        end
    end

    // return address is the call pc plus 4, no delay slot
    always_ff @(posedge clk) begin
        if (advance && is_call) begin
            stack_q[push_ptr] <= pc + 32'd4;
        end
    end

endmodule

// ==== source/next_pc_select.sv ====
module next_pc_select (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        stall,
    input  logic        redirect,
    input  logic [31:0] redirect_pc,
    input  logic        commit_valid,
    input  logic [31:0] commit_pc,
    input  logic        commit_taken,
    input  logic [31:0] commit_target,
    pred_if.sel         pred,
    update_if.src       upd,
    output logic [31:0] pc,
    output logic [31:0] next_pc,
    output logic [1:0]  pred_src,
    output logic        advance
);

    // redirect, then ras, then taken btb hit, then sequential
    always_comb begin
        if (redirect) begin
            next_pc = redirect_pc;
            pred_src = fetch_pkg::src_redirect;
        end else if (pred.ras_hit) begin
            next_pc = pred.ras_target;
            pred_src = fetch_pkg::src_ras;
        end else if (pred.btb_hit && pred.btb_taken) begin
            next_pc = pred.btb_target;
            pred_src = fetch_pkg::src_btb;
        end else begin
            next_pc = pc + 32'd4;
            pred_src = fetch_pkg::src_seq;
        end
    end

    // a redirect is never held off by stall
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= fetch_pkg::reset_vector;
        end else if (redirect || !stall) begin
            pc <= next_pc;
        end
    end

    assign advance = !stall && !redirect;

    // commit strobe straight into the btb
    assign upd.valid = commit_valid;
    assign upd.pc = commit_pc;
    assign upd.taken = commit_taken;
    assign upd.target = commit_target;

endmodule

// ==== source/fetch_predict.sv ====
module fetch_predict (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        stall,
    input  logic [31:0] instr,
    input  logic        redirect,
    input  logic [31:0] redirect_pc,
    input  logic        commit_valid,
    input  logic [31:0] commit_pc,
    input  logic        commit_taken,
    input  logic [31:0] commit_target,
    output logic [31:0] pc,
    output logic [31:0] next_pc,
    output logic [1:0]  pred_src
);

    logic advance;

    pred_if   pred_bus ();
    update_if upd_bus ();

    btb_predictor i_btb_predictor (
        .clk  (clk),
        .rst_n(rst_n),
        .pc   (pc),
        .upd  (upd_bus.btb),
        .pred (pred_bus.btb)
    );

    // a redirect empties the stack
    return_stack i_return_stack (
        .clk    (clk),
        .rst_n  (rst_n),
        .pc     (pc),
        .instr  (instr),
        .advance(advance),
        .flush  (redirect),
        .pred   (pred_bus.ras)
    );

    next_pc_select i_next_pc_select (
        .clk          (clk),
        .rst_n        (rst_n),
        .stall        (stall),
        .redirect     (redirect),
        .redirect_pc  (redirect_pc),
        .commit_valid (commit_valid),
        .commit_pc    (commit_pc),
        .commit_taken (commit_taken),
        .commit_target(commit_target),
        .pred         (pred_bus.sel),
        .upd          (upd_bus.src),
        .pc           (pc),
        .next_pc      (next_pc),
        .pred_src     (pred_src),
        .advance      (advance)
    );

endmodule

// ==== bench/fetch_predict_assertions.sv ====
module fetch_predict_assertions (
    input logic        clk,
    input logic        rst_n,
    input logic        stall,
    input logic        redirect,
    input logic [31:0] redirect_pc,
    input logic [31:0] pc
);

    // fetch addresses stay on word boundaries
    pc_aligned: assert property (@(posedge clk) disable iff (!rst_n) pc[1:0] == 2'b00)
        else $error("pc is not word aligned");

    redirect_loads: assert property (@(posedge clk) disable iff (!rst_n)
        redirect |=> pc == $past(redirect_pc))
        else $error("pc did not take the redirect address");

    // stall freezes pc unless a redirect comes in
    stall_holds: assert property (@(posedge clk) disable iff (!rst_n)
        stall && !redirect |=> $stable(pc))
        else $error("pc moved while stalled");

endmodule

bind fetch_predict fetch_predict_assertions i_fetch_predict_assertions (
    .clk        (clk),
    .rst_n      (rst_n),
    .stall      (stall),
    .redirect   (redirect),
    .redirect_pc(redirect_pc),
    .pc         (pc)
);

// ==== bench/tb_fetch_predict.sv ====
module tb_fetch_predict;

    logic        clk;
    logic        rst_n;
    logic        stall;
    logic [31:0] instr;
    logic        redirect;
    logic [31:0] redirect_pc;
    logic        commit_valid;
    logic [31:0] commit_pc;
    logic        commit_taken;
    logic [31:0] commit_target;
    logic [31:0] pc;
    logic [31:0] next_pc;
    logic [1:0]  pred_src;

    // reference model of the btb arrays and the return stack
    logic        m_valid [fetch_pkg::btb_entries];
    logic [23:0] m_tag [fetch_pkg::btb_entries];
    logic [31:0] m_target [fetch_pkg::btb_entries];
    logic [1:0]  m_ctr [fetch_pkg::btb_entries];
    logic [31:0] m_ras [$];
    logic [31:0] m_pc;

    // dut responses of the last cycle, for test-specific checks
    logic [31:0] seen_next;
    logic [31:0] seen_src;
    int          cycles;

    fetch_predict i_fetch_predict (
        .clk          (clk),
        .rst_n        (rst_n),
        .stall        (stall),
        .instr        (instr),
        .redirect     (redirect),
        .redirect_pc  (redirect_pc),
        .commit_valid (commit_valid),
        .commit_pc    (commit_pc),
        .commit_taken (commit_taken),
        .commit_target(commit_target),
        .pc           (pc),
        .next_pc      (next_pc),
        .pred_src     (pred_src)
    );

    always #20 clk = ~clk;

    // the tests take about a hundred cycles
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= 2000) begin
            $display("timeout: the tests did not finish within 2000 cycles");
            $display("** FAIL **");
            $fatal(1, "cycle limit reached");
        end
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
            $display("** FAIL **");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    function automatic logic is_call_word(input fetch_pkg::instr_u w);
        return (w.j.opcode == fetch_pkg::op_jal)
            || (w.r.opcode == fetch_pkg::op_special && w.r.funct == fetch_pkg::funct_jalr
                && w.r.rd == fetch_pkg::reg_ra);
    endfunction

    function automatic logic is_return_word(input fetch_pkg::instr_u w);
        return w.r.opcode == fetch_pkg::op_special && w.r.funct == fetch_pkg::funct_jr
            && w.r.rs == fetch_pkg::reg_ra;
    endfunction

    function automatic logic [31:0] jal_word();
        fetch_pkg::instr_u w;
        w.j.opcode = fetch_pkg::op_jal;
        w.j.index = 26'($urandom());
        return w;
    endfunction

    function automatic logic [31:0] link_ra_word(input logic [4:0] rs, input logic [5:0] funct);
        fetch_pkg::instr_u w;
        w.r.opcode = fetch_pkg::op_special;
        w.r.rs = rs;
        w.r.rt = 5'd0;
        w.r.rd = (funct == fetch_pkg::funct_jalr) ? fetch_pkg::reg_ra : 5'd0;
        w.r.shamt = 5'd0;
        w.r.funct = funct;
        return w;
    endfunction

    // random load word, never a call or a return
    function automatic logic [31:0] filler_word();
        fetch_pkg::instr_u w;
        w = $urandom();
        w.r.opcode = 6'h23;
        return w;
    endfunction

    function automatic logic [31:0] rand_addr();
        logic [31:0] r;
        r = $urandom();
        return {r[31:2], 2'b00};
    endfunction

    // one fetch cycle, starting and ending on a falling edge
    task automatic cycle(input logic st, input logic [31:0] word, input logic rd,
                         input logic [31:0] rpc, input logic cv, input logic [31:0] cpc,
                         input logic ct, input logic [31:0] ctgt);
        fetch_pkg::instr_u w;
        logic [31:0] exp_next;
        logic [1:0]  exp_src;
        logic [5:0]  idx;
        logic [5:0]  cidx;
        stall = st;
        instr = word;
        redirect = rd;
        redirect_pc = rpc;
        commit_valid = cv;
        commit_pc = cpc;
        commit_taken = ct;
        commit_target = ctgt;
        w = word;
        idx = m_pc[7:2];
        if (rd) begin
            exp_next = rpc;
            exp_src = fetch_pkg::src_redirect;
        end else if (is_return_word(w) && m_ras.size() > 0) begin
            exp_next = m_ras[$];
            exp_src = fetch_pkg::src_ras;
        end else if (m_valid[idx] && m_tag[idx] == m_pc[31:8] && m_ctr[idx][1]) begin
            exp_next = m_target[idx];
            exp_src = fetch_pkg::src_btb;
        end else begin
            exp_next = m_pc + 32'd4;
            exp_src = fetch_pkg::src_seq;
        end
        #1;
        check_value("pc", pc, m_pc);
        check_value("next_pc", next_pc, exp_next);
        check_value("pred_src", {30'd0, pred_src}, {30'd0, exp_src});
        seen_next = next_pc;
        seen_src = {30'd0, pred_src};
        // stack moves only on an advancing edge
        if (rd) begin
            m_ras.delete();
        end else if (!st && is_call_word(w)) begin
            m_ras.push_back(m_pc + 32'd4);
            if (m_ras.size() > fetch_pkg::ras_depth) begin
                void'(m_ras.pop_front());
            end
        end else if (!st && is_return_word(w) && m_ras.size() > 0) begin
            void'(m_ras.pop_back());
        end
        // training ignores stall
        if (cv) begin
            cidx = cpc[7:2];
            if (m_valid[cidx] && m_tag[cidx] == cpc[31:8]) begin
                if (ct && m_ctr[cidx] != 2'd3) begin
                    m_ctr[cidx] = m_ctr[cidx] + 2'd1;
                end else if (!ct && m_ctr[cidx] != 2'd0) begin
                    m_ctr[cidx] = m_ctr[cidx] - 2'd1;
                end
                if (ct) begin
                    m_target[cidx] = ctgt;
                end
            end else if (ct) begin
                m_valid[cidx] = 1'b1;
                m_tag[cidx] = cpc[31:8];
                m_ctr[cidx] = 2'd2;
                m_target[cidx] = ctgt;
            end
        end
        if (rd || !st) begin
            m_pc = exp_next;
        end
        @(negedge clk);
    endtask

    task automatic fetch(input logic [31:0] word);
        cycle(1'b0, word, 1'b0, 32'd0, 1'b0, 32'd0, 1'b0, 32'd0);
    endtask

    task automatic stall_fetch(input logic [31:0] word);
        cycle(1'b1, word, 1'b0, 32'd0, 1'b0, 32'd0, 1'b0, 32'd0);
    endtask

    task automatic jump_to(input logic [31:0] addr);
        cycle(1'b0, filler_word(), 1'b1, addr, 1'b0, 32'd0, 1'b0, 32'd0);
    endtask

    task automatic commit_branch(input logic [31:0] bpc, input logic taken,
                                 input logic [31:0] tgt);
        cycle(1'b0, filler_word(), 1'b0, 32'd0, 1'b1, bpc, taken, tgt);
    endtask

    task automatic test_reset_seq();
        check_value("pc", pc, fetch_pkg::reset_vector);
        repeat (8) begin
            fetch(filler_word());
            check_value("pred_src", seen_src, 32'(fetch_pkg::src_seq));
        end
    endtask

    task automatic test_stall_redirect();
        logic [31:0] held;
        logic [31:0] dest;
        held = pc;
        repeat (4) stall_fetch(filler_word());
        check_value("pc", pc, held);
        fetch(jal_word());
        // stalled redirect against a live ras hit
        dest = rand_addr();
        cycle(1'b1, link_ra_word(fetch_pkg::reg_ra, fetch_pkg::funct_jr), 1'b1, dest,
              1'b0, 32'd0, 1'b0, 32'd0);
        check_value("pred_src", seen_src, 32'(fetch_pkg::src_redirect));
        check_value("pc", pc, dest);
        // and against a taken btb hit at dest plus 4
        commit_branch(dest + 32'd4, 1'b1, rand_addr());
        jump_to(rand_addr());
        check_value("pred_src", seen_src, 32'(fetch_pkg::src_redirect));
    endtask

    task automatic test_btb();
        logic [31:0] bp;
        logic [31:0] tgt;
        logic [31:0] nm;
        bp = rand_addr();
        tgt = rand_addr();
        commit_branch(bp, 1'b1, tgt);
        jump_to(bp);
        fetch(filler_word());
        check_value("pred_src", seen_src, 32'(fetch_pkg::src_btb));
        check_value("next_pc", seen_next, tgt);
        // weakly taken drops to weakly not taken
        commit_branch(bp, 1'b0, 32'd0);
        jump_to(bp);
        fetch(filler_word());
        check_value("pred_src", seen_src, 32'(fetch_pkg::src_seq));
        nm = rand_addr();
        commit_branch(nm, 1'b0, 32'd0);
        jump_to(nm);
        fetch(filler_word());
        check_value("pred_src", seen_src, 32'(fetch_pkg::src_seq));
        commit_branch(bp, 1'b1, tgt);
        jump_to(bp);
        fetch(filler_word());
        check_value("pred_src", seen_src, 32'(fetch_pkg::src_btb));
        // same index, different tag
        jump_to(bp ^ 32'h0001_0000);
        fetch(filler_word());
        check_value("pred_src", seen_src, 32'(fetch_pkg::src_seq));
    endtask

    task automatic test_ras_order();
        logic [31:0] base;
        logic [31:0] p;
        base = rand_addr();
        jump_to(base);
        fetch(jal_word());
        fetch(link_ra_word(5'd4, fetch_pkg::funct_jalr));
        fetch(link_ra_word(fetch_pkg::reg_ra, fetch_pkg::funct_jr));
        check_value("pred_src", seen_src, 32'(fetch_pkg::src_ras));
        check_value("next_pc", seen_next, base + 32'd8);
        fetch(link_ra_word(fetch_pkg::reg_ra, fetch_pkg::funct_jr));
        check_value("next_pc", seen_next, base + 32'd4);
        fetch(link_ra_word(fetch_pkg::reg_ra, fetch_pkg::funct_jr));
        check_value("pred_src", seen_src, 32'(fetch_pkg::src_seq));
        // ras beats a trained btb entry at the return
        p = rand_addr();
        cycle(1'b0, filler_word(), 1'b1, p, 1'b1, p + 32'd4, 1'b1, rand_addr());
        fetch(jal_word());
        fetch(link_ra_word(fetch_pkg::reg_ra, fetch_pkg::funct_jr));
        check_value("pred_src", seen_src, 32'(fetch_pkg::src_ras));
        check_value("next_pc", seen_next, p + 32'd4);
    endtask

    task automatic test_ras_overflow();
        logic [31:0] base;
        int i;
        base = rand_addr();
        jump_to(base);
        repeat (10) fetch(jal_word());
        for (i = 0; i < 8; i++) begin
            fetch(link_ra_word(fetch_pkg::reg_ra, fetch_pkg::funct_jr));
            check_value("pred_src", seen_src, 32'(fetch_pkg::src_ras));
            check_value("next_pc", seen_next, base + 32'd40 - 32'(4 * i));
        end
        fetch(link_ra_word(fetch_pkg::reg_ra, fetch_pkg::funct_jr));
        check_value("pred_src", seen_src, 32'(fetch_pkg::src_seq));
        repeat (2) stall_fetch(jal_word());
        fetch(link_ra_word(fetch_pkg::reg_ra, fetch_pkg::funct_jr));
        check_value("pred_src", seen_src, 32'(fetch_pkg::src_seq));
        fetch(jal_word());
        jump_to(rand_addr());
        fetch(link_ra_word(fetch_pkg::reg_ra, fetch_pkg::funct_jr));
        check_value("pred_src", seen_src, 32'(fetch_pkg::src_seq));
    endtask

    initial begin
        void'($urandom(32'hb199_6c8b));
        clk = 1'b0;
        rst_n = 1'b0;
        stall = 1'b0;
        instr = 32'd0;
        redirect = 1'b0;
        redirect_pc = 32'd0;
        commit_valid = 1'b0;
        commit_pc = 32'd0;
        commit_taken = 1'b0;
        commit_target = 32'd0;
        cycles = 0;
        m_pc = fetch_pkg::reset_vector;
        foreach (m_valid[i]) begin
            m_valid[i] = 1'b0;
        end
        m_ras.delete();
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        test_reset_seq();
        test_stall_redirect();
        test_btb();
        test_ras_order();
        test_ras_overflow();
        $display("** PASS **");
        $finish;
    end

endmodule

// ==== files.f ====
common/fetch_pkg.sv
common/pred_if.sv
common/update_if.sv
branch_predict/btb_predictor.sv
branch_predict/return_stack.sv
source/next_pc_select.sv
source/fetch_predict.sv
bench/fetch_predict_assertions.sv
bench/tb_fetch_predict.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_fetch_predict
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert -Wno-fatal
SIM_ARGS  ?=

SOURCES := $(shell cat $(FILELIST))

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build: $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

# exit status of the model is the pass or fail result
sim: build
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS)

clean:
	rm -rf $(OBJ_DIR)
